/* common/bpu_cfg.svh */
`ifndef BPU_CFG_SVH
`define BPU_CFG_SVH

////////////////////////////////////////////////////////////////////////////
// predictor table geometry
////////////////////////////////////////////////////////////////////////////

// counter table index, taken from pc just above the word offset
`define BHT_IDX_W 6

// target buffer index and stored tag
`define BTB_IDX_W 4
`define BTB_TAG_W 8

////////////////////////////////////////////////////////////////////////////
// fetch side
////////////////////////////////////////////////////////////////////////////

// first fetch address after reset
`define RESET_PC 32'h1c000000
// two words per bundle
`define FETCH_BYTES 8

`endif

/* common/bpu_pkg.sv */
package bpu_pkg;

    ////////////////////////////////////////////////////////////////////////
    // encodings
    ////////////////////////////////////////////////////////////////////////

    // major opcodes (inst[31:26]) of the control transfer group
    typedef enum logic [5:0] {
        bceqz_bcnez = 6'h12,
        jirl        = 6'h13,
        b           = 6'h14,
        bl          = 6'h15,
        beq         = 6'h16,
        bne         = 6'h17,
        blt         = 6'h18,
        bge         = 6'h19,
        bltu        = 6'h1a,
        bgeu        = 6'h1b
    } br_op_e;

    // 2-bit saturating counter, msb is the predicted direction
    typedef enum logic [1:0] {
        strong_nt = 2'b00,
        weak_nt   = 2'b01,
        weak_t    = 2'b10,
        strong_t  = 2'b11
    } ctr_e;

    ////////////////////////////////////////////////////////////////////////
    // bundles between fetch, predictor and backend
    ////////////////////////////////////////////////////////////////////////

    // words returned for the current fetch pc, slot 0 at pc
    typedef struct packed {
        logic [31:0] inst0;
        logic [31:0] inst1;
        logic [1:0]  slot_en;
    } fetch_bundle_t;

    // resolved branch from the backend, plus flush redirect
    typedef struct packed {
        logic        update_en;
        logic [31:0] pc;
        logic        taken_actual;
        logic [31:0] target;
        logic        flush;
        logic [31:0] flush_pc;
    } branch_update_t;

    typedef struct packed {
        logic        taken;
        logic        slot;
        logic [31:0] target;
        logic [1:0]  slot_valid;
        logic [1:0]  br_mask;
    } pred_t;

endpackage

/* bpu/bht.sv */
`timescale 1ns/1ps
`include "bpu_cfg.svh"

module bht (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [31:0]             rd_pc0,
    input  logic [31:0]             rd_pc1,
    input  bpu_pkg::branch_update_t upd,
    output logic                    taken0,
    output logic                    taken1
);
    import bpu_pkg::*;

    localparam int ENTRIES = 1 << `BHT_IDX_W;

    ctr_e ctr_q [ENTRIES];

    logic [`BHT_IDX_W-1:0] rd_idx0;
    logic [`BHT_IDX_W-1:0] rd_idx1;
    logic [`BHT_IDX_W-1:0] wr_idx;

    // one step toward the resolved direction, stuck at the strong ends
    function automatic ctr_e ctr_step(input ctr_e cur, input logic taken);
        ctr_e nxt;
        case (cur)
            strong_nt: nxt = taken ? weak_nt  : strong_nt;
            weak_nt:   nxt = taken ? weak_t   : strong_nt;
            weak_t:    nxt = taken ? strong_t : weak_nt;
            default:   nxt = taken ? strong_t : weak_t;
        endcase
        return nxt;
    endfunction

    // word aligned index
    assign rd_idx0 = rd_pc0[`BHT_IDX_W+1:2];
    assign rd_idx1 = rd_pc1[`BHT_IDX_W+1:2];
    assign wr_idx  = upd.pc[`BHT_IDX_W+1:2];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < ENTRIES; i++) begin
                ctr_q[i] <= weak_nt;
            end
        end else if (upd.update_en) begin
            ctr_q[wr_idx] <= ctr_step(ctr_q[wr_idx], upd.taken_actual);
        end
    end

    assign taken0 = ctr_q[rd_idx0] inside {weak_t, strong_t};
    assign taken1 = ctr_q[rd_idx1] inside {weak_t, strong_t};

endmodule

/* bpu/btb.sv */
`timescale 1ns/1ps
`include "bpu_cfg.svh"

module btb (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [31:0]             rd_pc0,
    input  logic [31:0]             rd_pc1,
    input  bpu_pkg::branch_update_t upd,
    output logic                    hit0,
    output logic                    hit1,
    output logic [31:0]             target0,
    output logic [31:0]             target1
);

    localparam int ENTRIES = 1 << `BTB_IDX_W;
    localparam int IDX_LSB = 2;
    localparam int TAG_LSB = IDX_LSB + `BTB_IDX_W;

    logic                  valid_q  [ENTRIES];
    logic [`BTB_TAG_W-1:0] tag_q    [ENTRIES];
    logic [31:0]           target_q [ENTRIES];

    logic [`BTB_IDX_W-1:0] rd_idx0;
    logic [`BTB_IDX_W-1:0] rd_idx1;
    logic [`BTB_IDX_W-1:0] wr_idx;
    logic [`BTB_TAG_W-1:0] rd_tag0;
    logic [`BTB_TAG_W-1:0] rd_tag1;
    logic [`BTB_TAG_W-1:0] wr_tag;
    logic                  wr_en;

    // index right above the word offset, tag right above the index
    assign rd_idx0 = rd_pc0[TAG_LSB-1:IDX_LSB];
    assign rd_idx1 = rd_pc1[TAG_LSB-1:IDX_LSB];
    assign wr_idx  = upd.pc[TAG_LSB-1:IDX_LSB];
    assign rd_tag0 = rd_pc0[TAG_LSB+`BTB_TAG_W-1:TAG_LSB];
    assign rd_tag1 = rd_pc1[TAG_LSB+`BTB_TAG_W-1:TAG_LSB];
    assign wr_tag  = upd.pc[TAG_LSB+`BTB_TAG_W-1:TAG_LSB];

    // only taken branches allocate
    assign wr_en = upd.update_en && upd.taken_actual;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < ENTRIES; i++) begin
                valid_q[i] <= 1'b0;
            end
        end else if (wr_en) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag_q[wr_idx]    <= wr_tag;
            target_q[wr_idx] <= upd.target;
        end
    end

    assign hit0    = valid_q[rd_idx0] && (tag_q[rd_idx0] == rd_tag0);
    assign hit1    = valid_q[rd_idx1] && (tag_q[rd_idx1] == rd_tag1);
    assign target0 = target_q[rd_idx0];
    assign target1 = target_q[rd_idx1];

endmodule

/* bpu/bpu.sv */
`timescale 1ns/1ps

module bpu (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [31:0]             pc,
    input  logic                    stall,
    input  bpu_pkg::fetch_bundle_t  bundle,
    input  bpu_pkg::branch_update_t upd,
    output bpu_pkg::pred_t          pred
);
    import bpu_pkg::*;

    logic [31:0] pc1;
    logic [1:0]  br_mask;
    logic [1:0]  ctr_taken;
    logic [1:0]  btb_hit;
    logic [31:0] btb_target0;
    logic [31:0] btb_target1;
    logic [1:0]  slot_take;

    // major opcode check only, no further decode
    function automatic logic is_branch(input logic [5:0] op);
        logic hit;
        case (op)
            bceqz_bcnez, jirl, b, bl, beq, bne, blt, bge, bltu, bgeu: hit = 1'b1;
            default: hit = 1'b0;
        endcase
        return hit;
    endfunction

    // slot 1 sits one word after the fetch pc
    assign pc1 = pc + 32'd4;

    assign br_mask[0] = is_branch(bundle.inst0[31:26]);
    assign br_mask[1] = is_branch(bundle.inst1[31:26]);

    bht u_bht (
        .clk,
        .rst_n,
        .rd_pc0 (pc),
        .rd_pc1 (pc1),
        .upd,
        .taken0 (ctr_taken[0]),
        .taken1 (ctr_taken[1])
    );

    btb u_btb (
        .clk,
        .rst_n,
        .rd_pc0  (pc),
        .rd_pc1  (pc1),
        .upd,
        .hit0    (btb_hit[0]),
        .hit1    (btb_hit[1]),
        .target0 (btb_target0),
        .target1 (btb_target1)
    );

    // taken needs a target too, a counter alone cannot redirect
    assign slot_take = bundle.slot_en & br_mask & ctr_taken & btb_hit;

    always_comb begin
        pred = '0;
        if (!stall) begin
            pred.br_mask       = br_mask;
            pred.slot_valid[0] = bundle.slot_en[0];
            // anything after a taken slot 0 is on the wrong path
            pred.slot_valid[1] = bundle.slot_en[1] & ~slot_take[0];
            if (slot_take[0]) begin
                pred.taken  = 1'b1;
                pred.slot   = 1'b0;
                pred.target = btb_target0;
            end else if (slot_take[1]) begin
                pred.taken  = 1'b1;
                pred.slot   = 1'b1;
                pred.target = btb_target1;
            end
        end
    end

endmodule

/* hdl/pc_gen.sv */
`timescale 1ns/1ps
`include "bpu_cfg.svh"

module pc_gen (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    stall,
    input  bpu_pkg::pred_t          pred,
    input  bpu_pkg::branch_update_t upd,
    output logic [31:0]             pc
);

    logic [31:0] pc_seq;

    ////////////////////////////////////////////////////////////////////////
    // next fetch address
    ////////////////////////////////////////////////////////////////////////

    // fall through to the next aligned bundle
    assign pc_seq = pc + 32'(`FETCH_BYTES);

    // backend flush beats everything, even a held fetch
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= `RESET_PC;
        end else if (upd.flush) begin
            pc <= upd.flush_pc;
        end else if (stall) begin
            pc <= pc;
        end else if (pred.taken) begin
            pc <= pred.target;
        end else begin
            pc <= pc_seq;
        end
    end

endmodule

/* hdl/fetch_predict_top.sv */
`timescale 1ns/1ps

module fetch_predict_top (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    stall,
    input  bpu_pkg::fetch_bundle_t  bundle,
    input  bpu_pkg::branch_update_t upd,
    output logic [31:0]             fetch_pc,
    output bpu_pkg::pred_t          pred
);

    ////////////////////////////////////////////////////////////////////////
    // fetch address register
    ////////////////////////////////////////////////////////////////////////

    pc_gen u_pc_gen (
        .clk,
        .rst_n,
        .stall,
        .pred,
        .upd,
        .pc    (fetch_pc)
    );

    ////////////////////////////////////////////////////////////////////////
    // prediction for the bundle at fetch_pc, same cycle
    ////////////////////////////////////////////////////////////////////////

    bpu u_bpu (
        .clk,
        .rst_n,
        .pc     (fetch_pc),
        .stall,
        .bundle,
        .upd,
        .pred
    );

endmodule

/* verif/tb_fetch_predict.sv */
`timescale 1ns/1ps
`include "bpu_cfg.svh"

module tb_fetch_predict;
    import bpu_pkg::*;

    localparam int STIM_CYCLES = 120;
    localparam int MARGIN      = 40;

    logic           clk;
    logic           rst_n;
    logic           stall;
    fetch_bundle_t  bundle;
    branch_update_t upd;
    logic [31:0]    fetch_pc;
    pred_t          pred;

    // reference state
    int                    ref_ctr    [1 << `BHT_IDX_W];
    logic                  ref_valid  [1 << `BTB_IDX_W];
    logic [`BTB_TAG_W-1:0] ref_tag    [1 << `BTB_IDX_W];
    logic [31:0]           ref_target [1 << `BTB_IDX_W];
    logic [31:0]           exp_pc;
    pred_t                 e_pred;
    logic [1:0]            e_take;
    logic [1:0]            e_br;
    int                    errors;
    int                    taken_seen;

    fetch_predict_top uut (
        .clk,
        .rst_n,
        .stall,
        .bundle,
        .upd,
        .fetch_pc,
        .pred
    );

    always #10 clk = ~clk;

    function automatic int ctr_index(input logic [31:0] a);
        return int'(a[`BHT_IDX_W+1:2]);
    endfunction

    function automatic int btb_index(input logic [31:0] a);
        return int'(a[`BTB_IDX_W+1:2]);
    endfunction

    function automatic logic [`BTB_TAG_W-1:0] tag_of(input logic [31:0] a);
        return a[`BTB_IDX_W+`BTB_TAG_W+1:`BTB_IDX_W+2];
    endfunction

    // control transfer group is 0x12 through 0x1b
    function automatic logic op_is_branch(input logic [5:0] op);
        return (op >= 6'h12) && (op <= 6'h1b);
    endfunction

    function automatic logic predicts(input logic [31:0] a);
        return (ref_ctr[ctr_index(a)] >= 2) && ref_valid[btb_index(a)]
            && (ref_tag[btb_index(a)] == tag_of(a));
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        e_pred    = '0;
        e_br[0]   = op_is_branch(bundle.inst0[31:26]);
        e_br[1]   = op_is_branch(bundle.inst1[31:26]);
        e_take[0] = bundle.slot_en[0] && e_br[0] && predicts(exp_pc);
        e_take[1] = bundle.slot_en[1] && e_br[1] && predicts(exp_pc + 32'd4);
        if (!stall) begin
            e_pred.br_mask    = e_br;
            e_pred.slot_valid = {bundle.slot_en[1] && !e_take[0], bundle.slot_en[0]};
            if (e_take[0]) begin
                e_pred.taken  = 1'b1;
                e_pred.target = ref_target[btb_index(exp_pc)];
            end else if (e_take[1]) begin
                e_pred.taken  = 1'b1;
                e_pred.slot   = 1'b1;
                e_pred.target = ref_target[btb_index(exp_pc + 32'd4)];
            end
        end
    end

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            exp_pc <= `RESET_PC;
            foreach (ref_ctr[i]) ref_ctr[i] <= 1;
            foreach (ref_valid[i]) ref_valid[i] <= 1'b0;
        end else begin
            if (upd.flush) begin
                exp_pc <= upd.flush_pc;
            end else if (!stall) begin
                exp_pc <= e_pred.taken ? e_pred.target : exp_pc + 32'd8;
            end
            if (upd.update_en) begin
                if (upd.taken_actual) begin
                    ref_ctr[ctr_index(upd.pc)] <= (ref_ctr[ctr_index(upd.pc)] == 3) ?
                        3 : ref_ctr[ctr_index(upd.pc)] + 1;
                    ref_valid[btb_index(upd.pc)]  <= 1'b1;
                    ref_tag[btb_index(upd.pc)]    <= tag_of(upd.pc);
                    ref_target[btb_index(upd.pc)] <= upd.target;
                end else begin
                    ref_ctr[ctr_index(upd.pc)] <= (ref_ctr[ctr_index(upd.pc)] == 0) ?
                        0 : ref_ctr[ctr_index(upd.pc)] - 1;
                end
            end
        end
    end

    task automatic value_fail(input string name, input logic [31:0] e, input logic [31:0] g);
        errors++;
        $display("Fail at %0t ns: %s expected %h, got %h", $time, name, e, g);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////////////////////

    a_pc: assert property (@(posedge clk) disable iff (!rst_n) fetch_pc == exp_pc)
        else value_fail("fetch_pc", $sampled(exp_pc), $sampled(fetch_pc));
    a_taken: assert property (@(posedge clk) disable iff (!rst_n) pred.taken == e_pred.taken)
        else value_fail("pred.taken", $sampled(e_pred.taken), $sampled(pred.taken));
    a_slot: assert property (@(posedge clk) disable iff (!rst_n) pred.slot == e_pred.slot)
        else value_fail("pred.slot", $sampled(e_pred.slot), $sampled(pred.slot));
    a_target: assert property (@(posedge clk) disable iff (!rst_n) pred.target == e_pred.target)
        else value_fail("pred.target", $sampled(e_pred.target), $sampled(pred.target));
    a_valid: assert property (@(posedge clk) disable iff (!rst_n)
        pred.slot_valid == e_pred.slot_valid)
        else value_fail("pred.slot_valid", $sampled(e_pred.slot_valid),
                        $sampled(pred.slot_valid));
    a_mask: assert property (@(posedge clk) disable iff (!rst_n) pred.br_mask == e_pred.br_mask)
        else value_fail("pred.br_mask", $sampled(e_pred.br_mask), $sampled(pred.br_mask));

    always @(posedge clk) begin
        if (rst_n && pred.taken) begin
            taken_seen++;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] plain_word();
        logic [31:0] w;
        w = $urandom;
        // 0x12..0x1b all have bit 31 clear
        if (op_is_branch(w[31:26])) w[31] = 1'b1;
        return w;
    endfunction

    function automatic logic [31:0] branch_word();
        logic [31:0] w;
        w         = $urandom;
        w[31:26]  = 6'h12 + 6'($urandom % 10);
        return w;
    endfunction

    function automatic branch_update_t make_upd(input logic en, input logic [31:0] a,
                                                input logic tk, input logic [31:0] tgt,
                                                input logic fl, input logic [31:0] fpc);
        branch_update_t u;
        u.update_en    = en;
        u.pc           = a;
        u.taken_actual = tk;
        u.target       = tgt;
        u.flush        = fl;
        u.flush_pc     = fpc;
        return u;
    endfunction

    task automatic apply(input logic st, input logic [31:0] w0, input logic [31:0] w1,
                         input logic [1:0] en, input branch_update_t u);
        @(posedge clk);
        stall  <= st;
        bundle <= '{inst0: w0, inst1: w1, slot_en: en};
        upd    <= u;
    endtask

    task automatic idle(input int n);
        repeat (n) apply(1'b0, plain_word(), plain_word(), 2'b11, '0);
    endtask

    task automatic train(input logic [31:0] a, input logic [31:0] tgt, input logic tk);
        apply(1'b0, plain_word(), plain_word(), 2'b11, make_upd(1'b1, a, tk, tgt, 1'b0, '0));
    endtask

    task automatic redirect(input logic [31:0] a);
        apply(1'b0, plain_word(), plain_word(), 2'b11, make_upd(1'b0, '0, 1'b0, '0, 1'b1, a));
    endtask

    initial begin : stimulus
        logic [31:0] p;
        logic [31:0] q;
        logic [31:0] t0;
        logic [31:0] t1;
        void'($urandom(32'hbed79a53));
        clk        = 1'b0;
        rst_n      = 1'b0;
        stall      = 1'b0;
        bundle     = '0;
        upd        = '0;
        errors     = 0;
        taken_seen = 0;
        p  = $urandom & 32'hffff_fff8;
        q  = p ^ 32'h0000_0f00;
        t0 = $urandom & 32'hffff_fffc;
        t1 = $urandom & 32'hffff_fffc;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        idle(6);

        // trained slot 0, then slot 1 one word later
        train(p, t0, 1'b1);
        train(p, t0, 1'b1);
        redirect(p);
        apply(1'b0, branch_word(), plain_word(), 2'b01, '0);
        idle(1);
        train(p + 32'd4, t1, 1'b1);
        train(p + 32'd4, t1, 1'b1);
        redirect(p);
        apply(1'b0, plain_word(), branch_word(), 2'b11, '0);
        idle(1);

        // no branch opcode, then slot disabled
        redirect(p);
        apply(1'b0, plain_word(), plain_word(), 2'b11, '0);
        redirect(p);
        apply(1'b0, branch_word(), plain_word(), 2'b10, '0);
        idle(2);

        // counter walk down from strong taken
        repeat (3) train(q, t1, 1'b1);
        train(q, t1, 1'b0);
        redirect(q);
        apply(1'b0, branch_word(), plain_word(), 2'b11, make_upd(1'b1, q, 1'b0, t1, 1'b0, '0));
        redirect(q);
        apply(1'b0, branch_word(), plain_word(), 2'b11, '0);
        idle(1);

        // q shares both table entries with p, so slot 0 at p is trained again
        train(p, t0, 1'b1);
        train(p, t0, 1'b1);

        // flush over stall and over a taken prediction, plain stall, both slots taken
        redirect(p);
        repeat (3) apply(1'b1, branch_word(), branch_word(), 2'b11, '0);
        apply(1'b1, branch_word(), branch_word(), 2'b11, make_upd(1'b0, '0, 1'b0, '0, 1'b1, q));
        redirect(p);
        apply(1'b0, branch_word(), plain_word(), 2'b11, make_upd(1'b0, '0, 1'b0, '0, 1'b1, q));
        redirect(p);
        apply(1'b0, branch_word(), branch_word(), 2'b11, '0);
        idle(1);

        // mixed traffic around the trained addresses
        repeat (40) begin
            apply(($urandom % 4) == 0,
                  ($urandom % 2) ? branch_word() : plain_word(),
                  ($urandom % 2) ? branch_word() : plain_word(),
                  2'($urandom),
                  make_upd(($urandom % 3) == 0, ($urandom % 2) ? p + 32'd4 : q,
                           1'($urandom), t0, ($urandom % 4) == 0, ($urandom % 2) ? p : q));
        end
        idle(2);
        @(posedge clk);
        #1;
        if (taken_seen == 0) begin
            errors++;
            $display("no predicted-taken fetch was seen during the run");
        end
        $display("checks done, %0d errors", errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        #((STIM_CYCLES + MARGIN) * 20);
        $display("run timed out before the stimulus finished");
        $display("Something failed");
        $finish;
    end

endmodule

/* fetch_predict_top.f */
+incdir+common
common/bpu_pkg.sv
bpu/bht.sv
bpu/btb.sv
bpu/bpu.sv
hdl/pc_gen.sv
hdl/fetch_predict_top.sv
verif/tb_fetch_predict.sv
